// ==== hdl/splitter_pkg.sv ====
`default_nettype none

package splitter_pkg;

    // number of slot registers, the rotation depends on it
    localparam int SLOTS = 4;

    // default payload width
    localparam int DEFAULT_DATA_W = 48;

    // write and read pointer
    typedef logic [1:0] slot_idx_t;

    // one toggle or flip bit per slot
    typedef logic [SLOTS-1:0] slot_flags_t;

    // read pointer FSM
    typedef enum logic [1:0] {
        SEL_SLOT0 = 2'd0,
        SEL_SLOT1 = 2'd1,
        SEL_SLOT2 = 2'd2,
        SEL_SLOT3 = 2'd3
    } sel_state_t;

endpackage

`default_nettype wire

// ==== hdl/splitter_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module splitter_capture
    import splitter_pkg::*;
#(
    parameter int DATA_W = DEFAULT_DATA_W
) (
    input  wire logic              clock_r2p,
    input  wire logic              rst_n,
    input  wire logic [DATA_W-1:0] data_r2p,
    input  wire logic              strobe_r2p,
    input  wire logic              state_r2p,
    output logic      [DATA_W-1:0] slot_data [SLOTS],
    output slot_flags_t            slot_flags,
    output logic                   state_reg
);

    logic      strobe_d;
    logic      state_d1;
    logic      new_word;
    slot_idx_t wr_ptr;
    slot_idx_t wr_ptr_next;

    // copy of the strobe for toggle detection
    always_ff @(posedge clock_r2p or negedge rst_n) begin
        if (!rst_n) begin
            strobe_d <= 1'b0;
        end else begin
            strobe_d <= strobe_r2p;
        end
    end

    // any toggle while the stream is up carries a word
    assign new_word = (strobe_r2p != strobe_d) && state_r2p;

    always_comb begin
        wr_ptr_next = wr_ptr + slot_idx_t'(1);
    end

    // round-robin write pointer, parked on slot 0 between streams
    always_ff @(posedge clock_r2p or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (!state_r2p) begin
            wr_ptr <= '0;
        end else if (new_word) begin
            wr_ptr <= wr_ptr_next;
        end
    end

    // slot registers
    always_ff @(posedge clock_r2p or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SLOTS; i++) begin
                slot_data[i] <= '0;
            end
        end else if (new_word) begin
            for (int i = 0; i < SLOTS; i++) begin
                if (wr_ptr == slot_idx_t'(i)) begin
                    slot_data[i] <= data_r2p;
                end
            end
        end
    end

    // flag flips with every write to its slot
    // the receiver only looks for changes, never for the level
    always_ff @(posedge clock_r2p or negedge rst_n) begin
        if (!rst_n) begin
            slot_flags <= '0;
        end else if (new_word) begin
            for (int i = 0; i < SLOTS; i++) begin
                if (wr_ptr == slot_idx_t'(i)) begin
                    slot_flags[i] <= ~slot_flags[i];
                end
            end
        end
    end

    // state level delayed two cycles so the last flags lead it
    always_ff @(posedge clock_r2p or negedge rst_n) begin
        if (!rst_n) begin
            state_d1  <= 1'b0;
            state_reg <= 1'b0;
        end else begin
            state_d1  <= state_r2p;
            state_reg <= state_d1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/slot_flag_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

module slot_flag_sync
    import splitter_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire slot_flags_t slot_flags,
    input  wire logic        state_reg,
    output slot_flags_t      slot_flips,
    output logic             stream_end
);

    slot_flags_t flag_s1;
    slot_flags_t flag_s2;
    slot_flags_t flag_hist;

    logic state_s1;
    logic state_s2;
    logic state_hist;

    // two-flop synchronizers, one per slot flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_s1   <= '0;
            flag_s2   <= '0;
            flag_hist <= '0;
        end else begin
            flag_s1   <= slot_flags;
            flag_s2   <= flag_s1;
            flag_hist <= flag_s2;
        end
    end

    // a change against history means a fresh word in that slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_flips <= '0;
        end else begin
            slot_flips <= flag_s2 ^ flag_hist;
        end
    end

    // state level sync
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_s1   <= 1'b0;
            state_s2   <= 1'b0;
            state_hist <= 1'b0;
        end else begin
            state_s1   <= state_reg;
            state_s2   <= state_s1;
            state_hist <= state_s2;
        end
    end

    // falling edge closes the stream
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stream_end <= 1'b0;
        end else begin
            stream_end <= state_hist && !state_s2;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/slot_selector.sv ====
`timescale 1ns/100ps
`default_nettype none

module slot_selector
    import splitter_pkg::*;
#(
    parameter int DATA_W = DEFAULT_DATA_W
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [DATA_W-1:0] slot_data [SLOTS],
    input  wire slot_flags_t       slot_flips,
    input  wire logic              stream_end,
    output logic      [DATA_W-1:0] word,
    output logic                   word_valid
);

    sel_state_t rd_state;
    sel_state_t rd_next;
    slot_idx_t  rd_idx;
    logic       advance;

    always_comb begin
        rd_idx = slot_idx_t'(rd_state);
    end

    // only the flip of the slot we wait on counts
    assign advance = slot_flips[rd_idx];

    always_comb begin
        case (rd_state)
            SEL_SLOT0: rd_next = SEL_SLOT1;
            SEL_SLOT1: rd_next = SEL_SLOT2;
            SEL_SLOT2: rd_next = SEL_SLOT3;
            SEL_SLOT3: rd_next = SEL_SLOT0;
            default:   rd_next = SEL_SLOT0;
        endcase
    end

    // read pointer, stream end wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= SEL_SLOT0;
        end else if (stream_end) begin
            rd_state <= SEL_SLOT0;
        end else if (advance) begin
            rd_state <= rd_next;
        end
    end

    // slot is stable here, it was written before its flag moved
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word <= '0;
        end else if (advance) begin
            word <= slot_data[rd_idx];
        end
    end

    // one pulse per delivered word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= advance;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/four_slot_receiver.sv ====
`timescale 1ns/100ps
`default_nettype none

module four_slot_receiver
    import splitter_pkg::*;
#(
    parameter int DATA_W = DEFAULT_DATA_W
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              clock_r2p,
    input  wire logic [DATA_W-1:0] data_r2p,
    input  wire logic              strobe_r2p,
    input  wire logic              state_r2p,
    output logic      [DATA_W-1:0] word,
    output logic                   word_valid
);

    logic [DATA_W-1:0] slot_data [SLOTS];
    slot_flags_t       slot_flags;
    logic              state_reg;
    slot_flags_t       slot_flips;
    logic              stream_end;

    // sender clock domain
    splitter_capture #(
        .DATA_W(DATA_W)
    ) u_capture (
        .clock_r2p (clock_r2p),
        .rst_n     (rst_n),
        .data_r2p  (data_r2p),
        .strobe_r2p(strobe_r2p),
        .state_r2p (state_r2p),
        .slot_data (slot_data),
        .slot_flags(slot_flags),
        .state_reg (state_reg)
    );

    slot_flag_sync u_flag_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .slot_flags(slot_flags),
        .state_reg (state_reg),
        .slot_flips(slot_flips),
        .stream_end(stream_end)
    );

    slot_selector #(
        .DATA_W(DATA_W)
    ) u_selector (
        .clk       (clk),
        .rst_n     (rst_n),
        .slot_data (slot_data),
        .slot_flips(slot_flips),
        .stream_end(stream_end),
        .word      (word),
        .word_valid(word_valid)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter real CLK_HALF   = 5.0,
    parameter real R2P_HALF   = 6.5,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic clock_r2p,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // sender clock, slower than clk
    initial begin
        clock_r2p = 1'b0;
        forever #(R2P_HALF) clock_r2p = ~clock_r2p;
    end

    // release away from the active clk edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/four_slot_receiver_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module four_slot_receiver_asserts
    import splitter_pkg::*;
(
    input wire logic        clk,
    input wire logic        clock_r2p,
    input wire logic        rst_n,
    input wire logic        word_valid,
    input wire logic        stream_end,
    input wire slot_flags_t slot_flips,
    input wire sel_state_t  rd_state,
    input wire slot_flags_t slot_flags
);

    int unsigned fail_count = 0;

    // state trails the flags, so every flip is taken before the stream closes
    flips_before_end: assert property (@(posedge clk) disable iff (!rst_n)
        stream_end |-> (slot_flips == '0))
    else begin
        $error("stream_end arrived while a slot flip was still pending");
        fail_count++;
    end

    // pointer moves on a delivered word or on stream end
    pointer_moves: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(rd_state) |-> (word_valid || $past(stream_end)))
    else begin
        $error("read pointer moved without word_valid or stream_end");
        fail_count++;
    end

    one_flag_per_cycle: assert property (@(posedge clock_r2p) disable iff (!rst_n)
        $onehot0(slot_flags ^ $past(slot_flags)))
    else begin
        $error("more than one slot flag toggled in one sender cycle");
        fail_count++;
    end

endmodule

bind four_slot_receiver four_slot_receiver_asserts u_asserts (
    .clk       (clk),
    .clock_r2p (clock_r2p),
    .rst_n     (rst_n),
    .word_valid(word_valid),
    .stream_end(stream_end),
    .slot_flips(slot_flips),
    .rd_state  (u_selector.rd_state),
    .slot_flags(slot_flags)
);

`default_nettype wire

// ==== test/tb_four_slot_receiver.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_four_slot_receiver
    import splitter_pkg::*;
();

    localparam int DATA_W       = DEFAULT_DATA_W;
    localparam int VEC_LINES    = 64;
    localparam int RANDOM_WORDS = 24;
    localparam int DRAIN_LIMIT  = 400;

    logic              clk;
    logic              clock_r2p;
    logic              rst_n;
    logic [DATA_W-1:0] data_r2p;
    logic              strobe_r2p;
    logic              state_r2p;
    logic [DATA_W-1:0] word;
    logic              word_valid;

    // three entries per line: level, data, gap
    logic [DATA_W-1:0] vec_mem [3*VEC_LINES];

    logic [DATA_W-1:0] expected [$];
    string             expected_tag [$];
    int                sent = 0;
    int                received = 0;
    logic [31:0]       rng_state;

    tb_clock_gen u_clock_gen (
        .clk      (clk),
        .clock_r2p(clock_r2p),
        .rst_n    (rst_n)
    );

    four_slot_receiver #(
        .DATA_W(DATA_W)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .clock_r2p (clock_r2p),
        .data_r2p  (data_r2p),
        .strobe_r2p(strobe_r2p),
        .state_r2p (state_r2p),
        .word      (word),
        .word_valid(word_valid)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] seed);
        return seed * 32'd1664525 + 32'd1013904223;
    endfunction

    // one line on the sender side, the strobe toggles every time
    task automatic send_word(input string tag, input logic level,
                             input logic [DATA_W-1:0] value, input int gap);
        @(posedge clock_r2p);
        state_r2p  <= level;
        data_r2p   <= value;
        strobe_r2p <= ~strobe_r2p;
        if (level) begin
            expected.push_back(value);
            expected_tag.push_back(tag);
            sent++;
        end
        repeat (gap) @(posedge clock_r2p);
    endtask

    task automatic wait_for_reset(input int limit);
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("reset was never released");
        end
    endtask

    task automatic check_quiet_start(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (word_valid !== 1'b0) begin
                abort_run("word_valid rose after reset before any word was sent");
            end
        end
    endtask

    task automatic wait_for_drain(input string phase, input int limit);
        int cycles;
        cycles = 0;
        while (expected.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (expected.size() != 0) begin
            abort_run($sformatf("timeout in %s, %0d words never arrived",
                                phase, expected.size()));
        end
    endtask

    // receive side, word_valid is stable at the falling edge
    // every pulse is counted, extra ones show up in the word count
    always @(negedge clk) begin
        if (rst_n && word_valid) begin
            received++;
            if (expected.size() != 0) begin
                check_word(expected_tag.pop_front(), expected.pop_front(), word);
            end
        end
    end

    // a failed bound assertion ends the run right away
    always @(negedge clk) begin
        if (DUT.u_asserts.fail_count != 0) begin
            abort_run($sformatf("%0d assertion failures were reported",
                                DUT.u_asserts.fail_count));
        end
    end

    initial begin
        int                n_lines;
        int                gap;
        logic [63:0]       raw;
        logic [DATA_W-1:0] rdata;

        data_r2p   = '0;
        strobe_r2p = 1'b0;
        state_r2p  = 1'b0;
        rng_state  = 32'h95098a83;

        $readmemh("test/four_slot_vectors.txt", vec_mem);
        // list ends at the first level above 1
        n_lines = -1;
        for (int i = 0; i < VEC_LINES; i++) begin
            if (n_lines < 0 && vec_mem[3*i] > 1) begin
                n_lines = i;
            end
        end
        if (n_lines <= 0) begin
            abort_run("vector file is missing, empty or has no end marker");
        end

        wait_for_reset(20);
        check_quiet_start(20);

        for (int i = 0; i < n_lines; i++) begin
            send_word($sformatf("vector line %0d", i + 1), vec_mem[3*i][0],
                      vec_mem[3*i+1], int'(vec_mem[3*i+2]));
        end
        wait_for_drain("vector streams", DRAIN_LIMIT);
        // late pulses from toggles with the stream down land here
        repeat (20) @(posedge clk);
        check_count("vector word count", sent, received);

        // random stream, level held high
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            rng_state = next_random(rng_state);
            raw[63:32] = rng_state;
            rng_state = next_random(rng_state);
            raw[31:0] = rng_state;
            rdata = raw[DATA_W-1:0];
            rng_state = next_random(rng_state);
            gap = int'(rng_state[31:30]);
            send_word($sformatf("random word %0d", i + 1), 1'b1, rdata, gap);
        end
        send_word("random stream close", 1'b0, '0, 8);
        wait_for_drain("random stream", DRAIN_LIMIT);

        // extra word_valid pulses would show up here
        repeat (20) @(posedge clk);
        check_count("total word count", sent, received);
        if (DUT.u_asserts.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d assertion failures were reported",
                                DUT.u_asserts.fail_count));
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/splitter_pkg.sv
hdl/splitter_capture.sv
hdl/slot_flag_sync.sv
hdl/slot_selector.sv
hdl/four_slot_receiver.sv
test/tb_clock_gen.sv
test/four_slot_receiver_asserts.sv
test/tb_four_slot_receiver.sv

// ==== Bender.yml ====
package:
  name: four_slot_receiver

sources:
  - files:
      - hdl/splitter_pkg.sv
      - hdl/splitter_capture.sv
      - hdl/slot_flag_sync.sv
      - hdl/slot_selector.sv
      - hdl/four_slot_receiver.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/four_slot_receiver_asserts.sv
      - test/tb_four_slot_receiver.sv

// ==== test/four_slot_vectors.txt ====
// columns: state level, data word (48 bit hex), idle clock_r2p cycles after the line
// level 0 toggles the strobe with the stream down, level ff ends the list
1 100000000001 0
1 100000000002 0
1 100000000003 0
1 100000000004 0
1 100000000005 0
1 100000000006 0
0 1dead0000000 1
0 1dead0000001 8
1 2000000000a1 2
1 2000000000a2 0
1 2000000000a3 1
1 2000000000a4 3
1 2000000000a5 0
0 2dead0000000 8
1 3ffffffffff0 0
1 300000000000 0
1 3aaaa5555aaa 2
0 3dead0000000 8
1 400000000001 0
1 400000000002 0
1 400000000003 0
1 400000000004 0
1 400000000005 0
1 400000000006 0
1 400000000007 0
1 400000000008 0
1 400000000009 0
0 4dead0000000 8
ff 000000000000 0
